// File: common/adapter_settings.svh
// widths, queue depth and error blanking data shared by the TL-UL SRAM adapter
// include this wherever one of these values is needed
`ifndef ADAPTER_SETTINGS_SVH
`define ADAPTER_SETTINGS_SVH

// TL-UL device port
`define TL_DW 64
`define TL_AW 32
`define TL_AIW 8
`define TL_SZW 2

// SRAM is two bus words wide with 1024 words
`define SRAM_DW 128
`define SRAM_AW 10

// requests that can be in flight at once
`define ADAPTER_DEPTH 2

// data returned in place of real data when a request fails
`define DATA_WHEN_ERROR 64'hbad0_da7a_bad0_da7a
`define DATA_WHEN_INSTR_ERROR 64'h0000_0000_0000_0000

`endif

// File: common/tlul_pkg.sv
// bus-side types of the adapter, TL-UL opcodes and the A/D channel bundles
// import into any module that touches the TL-UL port
`include "adapter_settings.svh"

package tlul_pkg;

  // opcodes carried on the A channel
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_opcode_e;

  // d opcodes share the encodings of the two put opcodes
  localparam tl_opcode_e AccessAck     = PutFullData;
  localparam tl_opcode_e AccessAckData = PutPartialData;

  // host to device, A channel plus the D channel ready
  typedef struct packed {
    logic                  a_valid;
    tl_opcode_e            a_opcode;
    logic [`TL_SZW-1:0]    a_size;
    logic [`TL_AIW-1:0]    a_source;
    logic [`TL_AW-1:0]     a_address;
    logic [`TL_DW/8-1:0]   a_mask;
    logic [`TL_DW-1:0]     a_data;
    // set for an instruction fetch
    logic                  a_instr;
    logic                  d_ready;
  } tl_h2d_t;

  // device to host, D channel plus the A channel ready
  typedef struct packed {
    logic                  d_valid;
    tl_opcode_e            d_opcode;
    logic [`TL_SZW-1:0]    d_size;
    logic [`TL_AIW-1:0]    d_source;
    logic [`TL_DW-1:0]     d_data;
    logic                  d_error;
    logic                  a_ready;
  } tl_d2h_t;

endpackage

// File: common/sram_adapter_pkg.sv
// memory-side and internal types of the adapter
// SRAM word and request, plus the entries of the tracking and response FIFOs
`include "adapter_settings.svh"

package sram_adapter_pkg;

  // bus words per SRAM word and the width of the offset that picks one
  localparam int words_per_line = `SRAM_DW / `TL_DW;
  localparam int woff_w = $clog2(words_per_line);

  // one SRAM word, seen flat or as bus words by offset
  typedef union packed {
    logic [`SRAM_DW-1:0]                   flat;
    logic [words_per_line-1:0][`TL_DW-1:0] words;
  } sram_word_u;

  // request towards the single-port SRAM
  typedef struct packed {
    logic                req;
    logic                we;
    logic [`SRAM_AW-1:0] addr;
    sram_word_u          wdata;
    // bit-level write enable
    sram_word_u          wmask;
  } sram_req_t;

  // what the D channel needs to answer one accepted A beat
  typedef struct packed {
    logic                is_read;
    logic                error;
    logic                instr;
    logic [`TL_SZW-1:0]  size;
    logic [`TL_AIW-1:0]  source;
  } req_entry_t;

  // how to cut the bus word out of returning read data
  typedef struct packed {
    logic [`TL_DW/8-1:0] mask;
    logic [woff_w-1:0]   woffset;
  } rd_slot_t;

  // read data waiting for the host
  typedef struct packed {
    logic [`TL_DW-1:0]   data;
    // uncorrectable error reported by the SRAM
    logic                error;
  } rsp_entry_t;

endpackage

// File: source/sync_fifo.sv
// synchronous FIFO used for every queue in the adapter
// with pass set an empty FIFO hands the write straight to the read side
`timescale 1ns/100ps

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 2,
  parameter bit pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [width-1:0] rdata_o
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wptr_q;
  logic [ptr_w-1:0] rptr_q;
  logic [cnt_w-1:0] count_q;
  logic             empty;
  logic             thru;
  logic             push;
  logic             pop;

  assign empty    = (count_q == '0);
  assign wready_o = (count_q != cnt_w'(depth));

  // forward path only exists while nothing is stored
  assign thru     = pass & empty;
  assign rvalid_o = thru ? wvalid_i : ~empty;
  assign rdata_o  = thru ? wdata_i : mem[rptr_q];

  // a forwarded beat that is read at once never lands in storage
  assign push = wvalid_i & wready_o & ~(thru & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == ptr_w'(depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == ptr_w'(depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  // the writer has to respect wready_o, a push into a full FIFO is lost
  no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i |-> wready_o);

endmodule

// File: tlul_sram_adapter/adapter_req_path.sv
// request side of the adapter that checks each A beat and drives the SRAM request
// every accepted beat is recorded in the request FIFO and every granted read in the slot FIFO
`timescale 1ns/100ps
`include "adapter_settings.svh"

module adapter_req_path #(
  parameter bit byte_access  = 1'b1,
  parameter bit err_on_write = 1'b0,
  parameter bit err_on_read  = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  tlul_pkg::tl_h2d_t            tl_a_i,
  input  logic                         en_ifetch_i,
  input  logic                         gnt_i,
  input  logic                         reqfifo_wready_i,
  input  logic                         slotfifo_wready_i,
  output sram_adapter_pkg::sram_req_t  sram_req_o,
  output logic                         a_ready_o,
  output logic                         reqfifo_wvalid_o,
  output sram_adapter_pkg::req_entry_t reqfifo_wdata_o,
  output logic                         slotfifo_wvalid_o,
  output sram_adapter_pkg::rd_slot_t   slotfifo_wdata_o
);

  import tlul_pkg::*;
  import sram_adapter_pkg::*;

  // byte address bits inside one SRAM word and inside one bus word
  localparam int sram_lsb = $clog2(`SRAM_DW / 8);
  localparam int bus_lsb  = $clog2(`TL_DW / 8);

  logic              is_read;
  logic              instr_err;
  logic              wr_err;
  logic              rd_err;
  logic              attr_err;
  logic              req_err;
  logic              fifo_space;
  logic              sram_go;
  logic              a_ack;
  logic [woff_w-1:0] woffset;
  sram_word_u        wdata;
  sram_word_u        wmask;

  // anything that is not a Get is handled as a write
  assign is_read = (tl_a_i.a_opcode == Get);

  // fetch while fetching is disabled
  assign instr_err = tl_a_i.a_instr & ~en_ifetch_i;
  // memory built as read-only or write-only
  assign wr_err    = err_on_write & ~is_read;
  assign rd_err    = err_on_read & is_read;
  // without byte access only full bus-word puts get through
  assign attr_err  = ~byte_access & ~is_read &
                     ((tl_a_i.a_mask != '1) || (tl_a_i.a_size != `TL_SZW'(bus_lsb)));

  assign req_err = instr_err | wr_err | rd_err | attr_err;

  // both tracking FIFOs need room before anything is taken
  assign fifo_space = reqfifo_wready_i & slotfifo_wready_i;
  // a failed request is accepted without a grant
  assign a_ready_o  = fifo_space & (gnt_i | req_err);
  assign a_ack      = tl_a_i.a_valid & a_ready_o;
  // only clean requests reach the SRAM
  assign sram_go    = tl_a_i.a_valid & fifo_space & ~req_err;

  // address bit 3 picks the bus word inside the SRAM word
  assign woffset = tl_a_i.a_address[bus_lsb +: woff_w];

  // place data and byte mask in the addressed half while the other half stays masked off
  always_comb begin
    wdata.flat = '0;
    wmask.flat = '0;
    for (int i = 0; i < `TL_DW / 8; i++) begin
      wmask.words[woffset][8*i +: 8] = {8{tl_a_i.a_mask[i]}};
      wdata.words[woffset][8*i +: 8] = tl_a_i.a_mask[i] ? tl_a_i.a_data[8*i +: 8] : 8'h00;
    end
  end

  assign sram_req_o = '{
    req:   sram_go,
    we:    ~is_read,
    addr:  tl_a_i.a_address[sram_lsb +: `SRAM_AW],
    wdata: wdata,
    wmask: wmask
  };

  // every accepted beat is answered whether it failed or not
  assign reqfifo_wvalid_o = a_ack;
  assign reqfifo_wdata_o  = '{
    is_read: is_read,
    error:   req_err,
    instr:   tl_a_i.a_instr,
    size:    tl_a_i.a_size,
    source:  tl_a_i.a_source
  };

  // reads remember where their bytes sit until the data comes back
  assign slotfifo_wvalid_o = sram_go & gnt_i & is_read;
  assign slotfifo_wdata_o  = '{
    mask:    tl_a_i.a_mask,
    woffset: woffset
  };

  // a_ready is only offered while both tracking FIFOs can take an entry
  a_ready_room_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_ready_o |-> reqfifo_wready_i && slotfifo_wready_i);

endmodule

// File: tlul_sram_adapter/adapter_rsp_path.sv
// response side of the adapter, cuts the bus word out of SRAM read data
// queues it and answers every request in order on the D channel
`timescale 1ns/100ps
`include "adapter_settings.svh"

module adapter_rsp_path (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         tl_d_ready_i,
  input  logic                         reqfifo_rvalid_i,
  input  sram_adapter_pkg::req_entry_t reqfifo_rdata_i,
  input  sram_adapter_pkg::rd_slot_t   slot_i,
  input  logic                         rvalid_i,
  input  sram_adapter_pkg::sram_word_u rdata_i,
  input  logic                         rerror_i,
  output tlul_pkg::tl_d2h_t            tl_d_o,
  output logic                         reqfifo_rready_o,
  output logic                         slotfifo_rready_o
);

  import tlul_pkg::*;
  import sram_adapter_pkg::*;

  logic [`TL_DW-1:0] rmask;
  logic [`TL_DW-1:0] rword;
  rsp_entry_t        rspfifo_wdata;
  rsp_entry_t        rspfifo_rdata;
  logic              rspfifo_rvalid;
  logic              rspfifo_rready;
  logic              head_read_ok;
  logic              d_valid;
  logic              d_error;
  logic              d_ack;
  logic [`TL_DW-1:0] blank_data;
  logic [`TL_DW-1:0] d_data;

  // byte mask of the oldest read, widened to bits
  always_comb begin
    for (int i = 0; i < `TL_DW / 8; i++) begin
      rmask[8*i +: 8] = {8{slot_i.mask[i]}};
    end
  end

  // pick the addressed half, bytes not asked for come back as zero
  assign rword         = rdata_i.words[slot_i.woffset] & rmask;
  assign rspfifo_wdata = '{data: rword, error: rerror_i};
  // slot is done as soon as its data is in the response FIFO
  assign slotfifo_rready_o = rvalid_i;

  // SRAM data cannot be stalled, so it is held here while the host is busy
  sync_fifo #(
    .width($bits(rsp_entry_t)),
    .depth(`ADAPTER_DEPTH),
    .pass (1'b1)
  ) u_rspfifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(rvalid_i),
    .wready_o(),
    .wdata_i (rspfifo_wdata),
    .rvalid_o(rspfifo_rvalid),
    .rready_i(rspfifo_rready),
    .rdata_o (rspfifo_rdata)
  );

  // head read that went to the SRAM and must wait for its data
  assign head_read_ok = reqfifo_rdata_i.is_read & ~reqfifo_rdata_i.error;

  // writes and failed requests answer right away
  assign d_valid = reqfifo_rvalid_i & (~head_read_ok | rspfifo_rvalid);
  assign d_error = reqfifo_rdata_i.error | (head_read_ok & rspfifo_rdata.error);

  assign blank_data = reqfifo_rdata_i.instr ? `DATA_WHEN_INSTR_ERROR : `DATA_WHEN_ERROR;

  always_comb begin
    if (d_error) begin
      d_data = blank_data;
    end else if (reqfifo_rdata_i.is_read) begin
      d_data = rspfifo_rdata.data;
    end else begin
      // plain write ack
      d_data = '0;
    end
  end

  assign tl_d_o = '{
    d_valid:  d_valid,
    d_opcode: reqfifo_rdata_i.is_read ? AccessAckData : AccessAck,
    d_size:   reqfifo_rdata_i.size,
    d_source: reqfifo_rdata_i.source,
    d_data:   d_data,
    d_error:  d_valid & d_error,
    a_ready:  1'b0
  };

  // request entry leaves on D accept, its read data with it
  assign d_ack            = d_valid & tl_d_ready_i;
  assign reqfifo_rready_o = d_ack;
  assign rspfifo_rready   = d_ack & head_read_ok;

  // read data only returns for a request still waiting in the request FIFO
  rvalid_tracked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> reqfifo_rvalid_i);

  // a stalled response holds its value until the host takes it
  d_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid && !tl_d_ready_i |=> d_valid && $stable(tl_d_o));

endmodule

// File: tlul_sram_adapter/tlul_sram_adapter.sv
// TL-UL device port in front of a single-port SRAM twice the bus width
// connects the request path, the response path and the two tracking FIFOs
`timescale 1ns/100ps
`include "adapter_settings.svh"

module tlul_sram_adapter #(
  parameter bit byte_access  = 1'b1,
  parameter bit err_on_write = 1'b0,
  parameter bit err_on_read  = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  tlul_pkg::tl_h2d_t            tl_i,
  output tlul_pkg::tl_d2h_t            tl_o,
  input  logic                         en_ifetch_i,
  output sram_adapter_pkg::sram_req_t  sram_req_o,
  input  logic                         gnt_i,
  input  logic                         rvalid_i,
  input  sram_adapter_pkg::sram_word_u rdata_i,
  input  logic                         rerror_i
);

  import tlul_pkg::*;
  import sram_adapter_pkg::*;

  // request FIFO, one entry per accepted A beat
  logic       reqfifo_wvalid;
  logic       reqfifo_wready;
  req_entry_t reqfifo_wdata;
  logic       reqfifo_rvalid;
  logic       reqfifo_rready;
  req_entry_t reqfifo_rdata;

  // read-slot FIFO, one entry per granted read
  logic       slotfifo_wvalid;
  logic       slotfifo_wready;
  rd_slot_t   slotfifo_wdata;
  logic       slotfifo_rready;
  rd_slot_t   slotfifo_rdata;

  logic       a_ready;
  tl_d2h_t    d_chan;

  adapter_req_path #(
    .byte_access (byte_access),
    .err_on_write(err_on_write),
    .err_on_read (err_on_read)
  ) u_req_path (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tl_a_i           (tl_i),
    .en_ifetch_i      (en_ifetch_i),
    .gnt_i            (gnt_i),
    .reqfifo_wready_i (reqfifo_wready),
    .slotfifo_wready_i(slotfifo_wready),
    .sram_req_o       (sram_req_o),
    .a_ready_o        (a_ready),
    .reqfifo_wvalid_o (reqfifo_wvalid),
    .reqfifo_wdata_o  (reqfifo_wdata),
    .slotfifo_wvalid_o(slotfifo_wvalid),
    .slotfifo_wdata_o (slotfifo_wdata)
  );

  // popped when the D beat is taken
  sync_fifo #(
    .width($bits(req_entry_t)),
    .depth(`ADAPTER_DEPTH),
    .pass (1'b0)
  ) u_reqfifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(reqfifo_wvalid),
    .wready_o(reqfifo_wready),
    .wdata_i (reqfifo_wdata),
    .rvalid_o(reqfifo_rvalid),
    .rready_i(reqfifo_rready),
    .rdata_o (reqfifo_rdata)
  );

  // popped when read data returns, so its head always matches rdata_i
  sync_fifo #(
    .width($bits(rd_slot_t)),
    .depth(`ADAPTER_DEPTH),
    .pass (1'b0)
  ) u_slotfifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(slotfifo_wvalid),
    .wready_o(slotfifo_wready),
    .wdata_i (slotfifo_wdata),
    .rvalid_o(),
    .rready_i(slotfifo_rready),
    .rdata_o (slotfifo_rdata)
  );

  adapter_rsp_path u_rsp_path (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tl_d_ready_i     (tl_i.d_ready),
    .reqfifo_rvalid_i (reqfifo_rvalid),
    .reqfifo_rdata_i  (reqfifo_rdata),
    .slot_i           (slotfifo_rdata),
    .rvalid_i         (rvalid_i),
    .rdata_i          (rdata_i),
    .rerror_i         (rerror_i),
    .tl_d_o           (d_chan),
    .reqfifo_rready_o (reqfifo_rready),
    .slotfifo_rready_o(slotfifo_rready)
  );

  // D channel from the response path, a_ready from the request path
  always_comb begin
    tl_o         = d_chan;
    tl_o.a_ready = a_ready;
  end

endmodule

// File: verification/tb_sram_model.sv
// behavioral single-port SRAM for the adapter testbench
// random grant, read data one cycle after the grant, one line flagged as uncorrectable
`timescale 1ns/100ps
`include "adapter_settings.svh"

module tb_sram_model #(
  parameter logic [`SRAM_AW-1:0] err_line = 10'h2a5
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  sram_adapter_pkg::sram_req_t  req_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output sram_adapter_pkg::sram_word_u rdata_o,
  output logic                         rerror_o
);

  import sram_adapter_pkg::*;

  integer     seed;
  sram_word_u mem [2**`SRAM_AW];

  // every bus word starts with its own line and offset in it
  initial begin
    seed = 83105;
    for (int i = 0; i < 2**`SRAM_AW; i++) begin
      for (int w = 0; w < words_per_line; w++) begin
        mem[i].words[w] = {20'h5eed0, 2'(w), 10'(i), 20'hc0de0, 2'(w), 10'(i)};
      end
    end
  end

  // grant about three cycles in four
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o <= 1'b0;
    end else begin
      gnt_o <= (($random(seed) & 3) != 0);
    end
  end

  // granted read returns on the next edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      rerror_o <= 1'b0;
    end else begin
      rvalid_o <= req_i.req & gnt_o & ~req_i.we;
      if (req_i.req && gnt_o && !req_i.we) begin
        rdata_o  <= mem[req_i.addr];
        rerror_o <= (req_i.addr == err_line);
      end
    end
  end

  // bit-masked write
  always @(posedge clk_i) begin
    if (req_i.req && gnt_o && req_i.we) begin
      mem[req_i.addr].flat <= (mem[req_i.addr].flat & ~req_i.wmask.flat) |
                              (req_i.wdata.flat & req_i.wmask.flat);
    end
  end

endmodule

// File: verification/tb_tlul_sram_adapter.sv
// testbench for the TL-UL SRAM adapter
// directed and random traffic, expected D beats come from a shadow memory model
`timescale 1ns/100ps
`include "adapter_settings.svh"

module tb_tlul_sram_adapter;

  import tlul_pkg::*;
  import sram_adapter_pkg::*;

  typedef struct packed {
    tl_opcode_e          opcode;
    logic [`TL_SZW-1:0]  size;
    logic [`TL_AIW-1:0]  source;
    logic [`TL_DW-1:0]   data;
    logic                error;
  } exp_rsp_t;

  localparam int drive_dly = 10;
  localparam int reset_cycles = 10;
  localparam int num_directed = 12;
  localparam int num_random = 200;
  // generous per-request budget under random grant and random d_ready
  localparam int cycle_limit = (num_directed + num_random) * 24 + reset_cycles + 100;
  localparam logic [`SRAM_AW-1:0] err_line = 10'h2a5;

  logic       clk_i = 1'b0;
  logic       rst_ni = 1'b0;
  logic       en_ifetch_i = 1'b0;
  logic       d_ready = 1'b1;
  logic       rand_ready = 1'b0;
  tl_h2d_t    a_req = '0;
  tl_h2d_t    tl_h2d;
  tl_d2h_t    tl_d2h;
  sram_req_t  sram_req;
  logic       gnt;
  logic       rvalid;
  sram_word_u rdata;
  logic       rerror;

  integer     seed = 83105;
  integer     ready_seed = 83105;
  int         errors = 0;
  int         accepted = 0;
  int         rsp_count = 0;
  int         sram_hits = 0;
  int         expected_hits = 0;
  int         cycles = 0;
  exp_rsp_t   exp_q [$];
  // one entry per bus word, index is line and offset
  logic [`TL_DW-1:0] shadow [2**(`SRAM_AW+1)];

  always #50 clk_i = ~clk_i;

  always_comb begin
    tl_h2d         = a_req;
    tl_h2d.d_ready = d_ready;
  end

  tlul_sram_adapter i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tl_i       (tl_h2d),
    .tl_o       (tl_d2h),
    .en_ifetch_i(en_ifetch_i),
    .sram_req_o (sram_req),
    .gnt_i      (gnt),
    .rvalid_i   (rvalid),
    .rdata_i    (rdata),
    .rerror_i   (rerror)
  );

  tb_sram_model #(
    .err_line(err_line)
  ) u_sram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (sram_req),
    .gnt_o   (gnt),
    .rvalid_o(rvalid),
    .rdata_o (rdata),
    .rerror_o(rerror)
  );

  // power-up contents of the memory model
  function automatic logic [`TL_DW-1:0] fill_word(logic [`SRAM_AW-1:0] line, logic off);
    return {20'h5eed0, 2'(off), line, 20'hc0de0, 2'(off), line};
  endfunction

  // expected D beat for one accepted A beat, updates the shadow memory on writes
  function automatic exp_rsp_t predict_response(tl_opcode_e op, logic [31:0] addr,
                                                logic [7:0] mask, logic [63:0] data,
                                                logic [1:0] size, logic [7:0] source,
                                                logic instr, logic fetch_en);
    exp_rsp_t          r;
    logic [10:0]       idx;
    logic [63:0]       bits;
    logic              is_read;
    idx = addr[13:3];
    for (int i = 0; i < 8; i++) begin
      bits[8*i +: 8] = {8{mask[i]}};
    end
    is_read  = (op == Get);
    r.opcode = is_read ? AccessAckData : AccessAck;
    r.size   = size;
    r.source = source;
    r.error  = 1'b0;
    r.data   = '0;
    if (instr && !fetch_en) begin
      // refused fetch never reaches the memory
      r.error = 1'b1;
      r.data  = `DATA_WHEN_INSTR_ERROR;
    end else if (is_read) begin
      expected_hits++;
      if (addr[13:4] == err_line) begin
        r.error = 1'b1;
        r.data  = instr ? `DATA_WHEN_INSTR_ERROR : `DATA_WHEN_ERROR;
      end else begin
        r.data = shadow[idx] & bits;
      end
    end else begin
      expected_hits++;
      shadow[idx] = (shadow[idx] & ~bits) | (data & bits);
    end
    return r;
  endfunction

  // drive one A beat and hold it until the adapter takes it
  task automatic send(tl_opcode_e op, logic [31:0] addr, logic [7:0] mask, logic [63:0] data,
                      logic [1:0] size, logic [7:0] source, logic instr, logic fetch_en);
    a_req.a_valid   = 1'b1;
    a_req.a_opcode  = op;
    a_req.a_address = addr;
    a_req.a_mask    = mask;
    a_req.a_data    = data;
    a_req.a_size    = size;
    a_req.a_source  = source;
    a_req.a_instr   = instr;
    en_ifetch_i     = fetch_en;
    do begin
      @(negedge clk_i);
    end while (!tl_d2h.a_ready);
    exp_q.push_back(predict_response(op, addr, mask, data, size, source, instr, fetch_en));
    accepted++;
    @(posedge clk_i);
    #(drive_dly);
    a_req.a_valid = 1'b0;
  endtask

  // wait until every expected response has been seen
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #(drive_dly);
  endtask

  task automatic random_traffic(int count);
    int         pick;
    tl_opcode_e op;
    logic [9:0] line;
    logic       off;
    logic [7:0] mask;
    logic       instr;
    for (int n = 0; n < count; n++) begin
      pick = $unsigned($random(seed)) % 3;
      op   = (pick == 0) ? Get : (pick == 1) ? PutFullData : PutPartialData;
      // small window of lines so reads hit recent writes and the error line
      line  = 10'h2a0 + 10'($unsigned($random(seed)) % 16);
      off   = 1'($random(seed));
      mask  = (op == PutFullData) ? 8'hff : 8'($random(seed));
      instr = (op == Get) && (($random(seed) & 3) == 0);
      send(op, {18'h0, line, off, 3'h0}, mask, {$random(seed), $random(seed)},
           (op == PutFullData) ? 2'd3 : 2'($random(seed)), 8'(n), instr, 1'($random(seed)));
      if (($random(seed) & 3) == 0) begin
        @(posedge clk_i);
        #(drive_dly);
      end
    end
  endtask

  task automatic compare_field(string name, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      $display("[FAIL] %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  // host back-pressure, random only in the mixed traffic phase
  always @(posedge clk_i) begin
    #(drive_dly);
    d_ready = rand_ready ? (($random(ready_seed) & 1) == 1) : 1'b1;
  end

  // every D beat is checked against the oldest expected response
  always @(negedge clk_i) begin : compare_d
    exp_rsp_t want;
    if (rst_ni && tl_d2h.d_valid && d_ready) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        $display("D response arrived with no request outstanding");
        errors++;
      end else begin
        want = exp_q.pop_front();
        compare_field("d_opcode", 64'(tl_d2h.d_opcode), 64'(want.opcode));
        compare_field("d_size", 64'(tl_d2h.d_size), 64'(want.size));
        compare_field("d_source", 64'(tl_d2h.d_source), 64'(want.source));
        compare_field("d_data", tl_d2h.d_data, want.data);
        compare_field("d_error", 64'(tl_d2h.d_error), 64'(want.error));
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && sram_req.req && gnt) begin
      sram_hits++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d responses missing", cycles, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    for (int i = 0; i < 2**`SRAM_AW; i++) begin
      shadow[{10'(i), 1'b0}] = fill_word(10'(i), 1'b0);
      shadow[{10'(i), 1'b1}] = fill_word(10'(i), 1'b1);
    end
    repeat (reset_cycles) @(posedge clk_i);
    #(drive_dly);
    rst_ni = 1'b1;
    @(posedge clk_i);
    #(drive_dly);

    // full writes and reads of both halves of one line
    send(PutFullData, 32'h0000_0100, 8'hff, 64'h0123_4567_89ab_cdef, 2'd3, 8'h01, 1'b0, 1'b1);
    send(PutFullData, 32'h0000_0108, 8'hff, 64'hfedc_ba98_7654_3210, 2'd3, 8'h02, 1'b0, 1'b1);
    send(Get, 32'h0000_0100, 8'hff, 64'h0, 2'd3, 8'h03, 1'b0, 1'b1);
    send(Get, 32'h0000_0108, 8'hff, 64'h0, 2'd3, 8'h04, 1'b0, 1'b1);

    // partial write, then reads with partial masks
    send(PutPartialData, 32'h0000_0100, 8'h0f, 64'h1111_2222_3333_4444, 2'd2, 8'h05, 1'b0, 1'b1);
    send(Get, 32'h0000_0100, 8'hf0, 64'h0, 2'd2, 8'h06, 1'b0, 1'b1);
    send(Get, 32'h0000_0100, 8'hff, 64'h0, 2'd3, 8'h07, 1'b0, 1'b1);
    send(Get, 32'h0000_0108, 8'h3c, 64'h0, 2'd2, 8'h08, 1'b0, 1'b1);

    // fetch with fetching disabled must not reach the memory
    drain();
    send(Get, 32'h0000_0108, 8'hff, 64'h0, 2'd3, 8'h09, 1'b1, 1'b0);
    drain();
    if (sram_hits != expected_hits) begin
      $display("SRAM saw %0d requests but %0d were expected around the refused fetch",
               sram_hits, expected_hits);
      errors++;
    end
    send(Get, 32'h0000_0108, 8'hff, 64'h0, 2'd3, 8'h0a, 1'b1, 1'b1);

    // line flagged as uncorrectable in the model
    send(Get, {18'h0, err_line, 1'b0, 3'h0}, 8'hff, 64'h0, 2'd3, 8'h0b, 1'b0, 1'b1);
    send(Get, {18'h0, err_line, 1'b1, 3'h0}, 8'h0f, 64'h0, 2'd2, 8'h0c, 1'b0, 1'b1);
    drain();

    // mixed traffic under random grant and random d_ready
    rand_ready = 1'b1;
    random_traffic(num_random);
    drain();
    rand_ready = 1'b0;

    if (rsp_count != accepted) begin
      $display("%0d responses seen for %0d accepted requests", rsp_count, accepted);
      errors++;
    end
    if (sram_hits != expected_hits) begin
      $display("SRAM saw %0d requests but %0d were expected", sram_hits, expected_hits);
      errors++;
    end
    $display("errors: %0d, accepted: %0d, responses: %0d", errors, accepted, rsp_count);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+common
common/tlul_pkg.sv
common/sram_adapter_pkg.sv
source/sync_fifo.sv
tlul_sram_adapter/adapter_req_path.sv
tlul_sram_adapter/adapter_rsp_path.sv
tlul_sram_adapter/tlul_sram_adapter.sv
verification/tb_sram_model.sv
verification/tb_tlul_sram_adapter.sv

// File: Makefile
# Verilator build and run of the TL-UL SRAM adapter testbench
TOP := tb_tlul_sram_adapter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
